// File: Bender.yml
package:
  name: combine

sources:
  - logic/combine_pkg.sv
  - logic/lane_fifo.sv
  - logic/lane_combiner.sv
  - logic/combine_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/combine_tb.sv

// File: dv/combine_model.svh
//##########################################################################
// reference model for the combiner testbench, included inside its module
// per-lane queues of accepted words, expected output words and compares
//##########################################################################
`ifndef COMBINE_MODEL_SVH
`define COMBINE_MODEL_SVH

// words accepted on each lane that have not reached the output yet
sample_word_u lane_q [num_lanes][$];
bit           last_q [num_lanes][$];

// 16-bit window of a channel total, wraps without saturation
function automatic logic [sample_w-1:0] window(input int total, input trunc_t code);
    int shifted;
    case (code)
        2'd1:    shifted = total >>> 1;
        2'd2:    shifted = total >>> 2;
        default: shifted = total;
    endcase
    return shifted[sample_w-1:0];
endfunction

// pops one word per unmasked lane and builds the expected output
task automatic model_output(
    input  trunc_t               code,
    input  logic [num_lanes-1:0] mask,
    output sample_word_u         exp_word,
    output bit                   exp_last
);
    int           sum_a;
    int           sum_b;
    sample_word_u w;
    sum_a    = 0;
    sum_b    = 0;
    exp_last = 1'b1;
    for (int i = 0; i < num_lanes; i++) begin
        if (!mask[i]) begin
            w        = lane_q[i].pop_front();
            sum_a    = sum_a + $signed(w.s.a);
            sum_b    = sum_b + $signed(w.s.b);
            exp_last = exp_last & last_q[i].pop_front();
        end
    end
    exp_word.s.a = window(sum_a, code);
    exp_word.s.b = window(sum_b, code);
endtask

task automatic check_word(input sample_word_u expected);
    if (out_data !== expected) begin
        $display("ERROR at %0t: out_data is %h, expected %h", $time, out_data.raw, expected.raw);
        halt_on_failure();
    end
endtask

task automatic check_last(input logic expected);
    if (out_last !== expected) begin
        $display("ERROR at %0t: out_last is %b, expected %b", $time, out_last, expected);
        halt_on_failure();
    end
endtask

`endif

// File: dv/combine_tb.sv
//##########################################################################
// testbench for the four-lane combiner driving random lanes into a queue model
// runs the phases in sequence and stops at the first mismatch
//##########################################################################
`timescale 1ns/1ps

module combine_tb import combine_pkg::*; ();

    localparam int words_per_lane = 400;
    localparam int masked_cycles  = 200;
    localparam int num_phases     = 9;
    // about five cycles per word and phase covers even the slow skew phases
    localparam int timeout_cycles = num_phases * words_per_lane * 5 + 2000;

    logic                         clk;
    logic                         arst_n;
    trunc_t                       trunc;
    logic [num_lanes-1:0]         lane_mask;
    logic [num_lanes-1:0]         in_valid;
    sample_word_u [num_lanes-1:0] in_data;
    logic [num_lanes-1:0]         in_last;
    logic [num_lanes-1:0]         in_ready;
    logic                         out_valid;
    sample_word_u                 out_data;
    logic                         out_last;
    logic                         out_ready;

    integer             seed;
    int                 valid_pct [num_lanes];
    int                 ready_pct;
    int                 issued [num_lanes];
    int                 sent [num_lanes];
    bit [num_lanes-1:0] accepted;
    int                 phase_outputs;
    int                 total_accepted;
    int                 cycles;
    bit                 saw_full;
    bit                 held;
    sample_word_u       held_data;
    logic               held_last;

    `include "combine_model.svh"

    combine_top i_combine_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .trunc     (trunc),
        .lane_mask (lane_mask),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .in_last   (in_last),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data),
        .out_last  (out_last),
        .out_ready (out_ready)
    );

    task automatic halt_on_failure();
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout: output stream did not drain within %0d cycles", timeout_cycles);
            halt_on_failure();
        end
    end

    // input acceptance, output compare and stall hold
    always @(posedge clk) begin
        sample_word_u exp_word;
        bit           exp_last;
        if (!arst_n) begin
            if (out_valid) begin
                $display("out_valid is high during reset");
                halt_on_failure();
            end
        end else begin
            if (out_valid && (total_accepted == 0 || &lane_mask)) begin
                $display("out_valid is high with no joined input words");
                halt_on_failure();
            end
            if (held) begin
                if (!out_valid) begin
                    $display("out_valid dropped while the output was stalled");
                    halt_on_failure();
                end
                check_word(held_data);
                check_last(held_last);
            end
            for (int i = 0; i < num_lanes; i++) begin
                if (!in_ready[i]) begin
                    saw_full = 1'b1;
                    if (lane_q[i].size() < lane_fifo_depth) begin
                        $display("in_ready low on lane %0d with only %0d words queued",
                                 i, lane_q[i].size());
                        halt_on_failure();
                    end
                end
                if (in_valid[i] && in_ready[i]) begin
                    lane_q[i].push_back(in_data[i]);
                    last_q[i].push_back(in_last[i]);
                    accepted[i]    = 1'b1;
                    sent[i]        = sent[i] + 1;
                    total_accepted = total_accepted + 1;
                end
            end
            if (out_valid && out_ready) begin
                for (int i = 0; i < num_lanes; i++) begin
                    if (!lane_mask[i] && lane_q[i].size() == 0) begin
                        $display("output word arrived with no input left on lane %0d", i);
                        halt_on_failure();
                    end
                end
                model_output(trunc, lane_mask, exp_word, exp_last);
                check_word(exp_word);
                check_last(exp_last);
                phase_outputs = phase_outputs + 1;
            end
            held      = out_valid && !out_ready;
            held_data = out_data;
            held_last = out_last;
        end
    end

    // one falling edge worth of lane and output stimulus
    task automatic drive_cycle();
        for (int i = 0; i < num_lanes; i++) begin
            // a pending word stays put until it transfers
            if (!(in_valid[i] && !accepted[i])) begin
                in_valid[i] = 1'b0;
                if (!lane_mask[i] && issued[i] < words_per_lane && chance(valid_pct[i])) begin
                    in_data[i].raw = $random(seed);
                    in_last[i]     = chance(50);
                    in_valid[i]    = 1'b1;
                    issued[i]      = issued[i] + 1;
                end
            end
            accepted[i] = 1'b0;
        end
        out_ready = chance(ready_pct);
    endtask

    function automatic bit phase_done();
        for (int i = 0; i < num_lanes; i++) begin
            if (!lane_mask[i] && (sent[i] < words_per_lane || lane_q[i].size() != 0)) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic start_phase(
        input trunc_t               code,
        input logic [num_lanes-1:0] mask,
        input int                   fast_pct,
        input int                   slow_lane,
        input int                   slow_pct,
        input int                   rdy_pct
    );
        @(negedge clk);
        trunc         = code;
        lane_mask     = mask;
        ready_pct     = rdy_pct;
        phase_outputs = 0;
        for (int i = 0; i < num_lanes; i++) begin
            issued[i]    = 0;
            sent[i]      = 0;
            valid_pct[i] = (i == slow_lane) ? slow_pct : fast_pct;
        end
    endtask

    task automatic run_phase(
        input trunc_t               code,
        input logic [num_lanes-1:0] mask,
        input int                   fast_pct,
        input int                   slow_lane,
        input int                   slow_pct,
        input int                   rdy_pct
    );
        start_phase(code, mask, fast_pct, slow_lane, slow_pct, rdy_pct);
        drive_cycle();
        while (!phase_done()) begin
            @(negedge clk);
            drive_cycle();
        end
        if (phase_outputs != words_per_lane) begin
            $display("trunc %0d mask %b gave %0d output words instead of %0d",
                     code, mask, phase_outputs, words_per_lane);
            halt_on_failure();
        end
    endtask

    initial begin
        seed           = 32'h4b536786;
        cycles         = 0;
        total_accepted = 0;
        phase_outputs  = 0;
        saw_full       = 1'b0;
        held           = 1'b0;
        accepted       = '0;
        arst_n         = 1'b0;
        trunc          = '0;
        lane_mask      = '0;
        in_valid       = '0;
        in_data        = '0;
        in_last        = '0;
        out_ready      = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        // out_valid has to stay low while idle after reset
        repeat (10) @(negedge clk);

        run_phase(2'd0, 4'b0000, 90, -1, 0, 100);
        run_phase(2'd1, 4'b0000, 70, -1, 0, 100);
        run_phase(2'd2, 4'b0000, 70, -1, 0, 100);
        run_phase(2'd3, 4'b0000, 70, -1, 0, 100);
        run_phase(2'd0, 4'b0101, 70, -1, 0, 80);
        run_phase(2'd2, 4'b1110, 70, -1, 0, 80);

        // one slow lane with back-pressure so the other FIFOs fill
        @(negedge clk);
        saw_full = 1'b0;
        run_phase(2'd0, 4'b0000, 100, 0, 15, 50);
        run_phase(2'd1, 4'b0000, 100, 3, 15, 50);
        if (!saw_full) begin
            $display("no lane FIFO ever filled during the skew phases");
            halt_on_failure();
        end

        start_phase(2'd0, 4'b1111, 100, -1, 0, 50);
        repeat (masked_cycles) begin
            drive_cycle();
            @(negedge clk);
        end

        $display("sim passed");
        $finish;
    end

endmodule

// File: files.f
+incdir+dv
logic/combine_pkg.sv
logic/lane_fifo.sv
logic/lane_combiner.sv
logic/combine_top.sv
dv/combine_tb.sv

// File: logic/combine_pkg.sv
//##########################################################################
// shared widths, FIFO depth and word views for the four-lane combiner
// modules pull this in with a wildcard import in their headers
//##########################################################################
package combine_pkg;

    // lane structure
    localparam int num_lanes = 4;
    localparam int sample_w  = 16;
    localparam int word_w    = 2 * sample_w;

    // four signed samples need two guard bits
    localparam int sum_w = sample_w + 2;

    // per-lane skew buffer
    localparam int lane_fifo_depth = 8;

    // output scaling code
    // 0 keeps the low bits of the sum, 3 is handled as 0
    typedef logic [1:0] trunc_t;

    localparam trunc_t trunc_div2 = 2'd1;
    localparam trunc_t trunc_div4 = 2'd2;

    // one lane word
    // raw view for transport, sample view for the arithmetic
    // channel a sits in the low half, channel b in the high half
    typedef union packed {
        logic [word_w-1:0] raw;
        struct packed {
            logic signed [sample_w-1:0] b;
            logic signed [sample_w-1:0] a;
        } s;
    } sample_word_u;

endpackage

// File: logic/combine_top.sv
//##########################################################################
// top level of the four-lane sample combiner
// one skew FIFO per input lane in front of the combining adder tree
//##########################################################################
`timescale 1ns/1ps

module combine_top import combine_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  trunc_t                       trunc,
    input  logic [num_lanes-1:0]         lane_mask,

    input  logic [num_lanes-1:0]         in_valid,
    input  sample_word_u [num_lanes-1:0] in_data,
    input  logic [num_lanes-1:0]         in_last,
    output logic [num_lanes-1:0]         in_ready,

    output logic                         out_valid,
    output sample_word_u                 out_data,
    output logic                         out_last,
    input  logic                         out_ready
);

    // FIFO read side into the join
    logic [num_lanes-1:0]         lane_valid;
    sample_word_u [num_lanes-1:0] lane_data;
    logic [num_lanes-1:0]         lane_last;
    logic [num_lanes-1:0]         lane_ready;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        lane_fifo i_lane_fifo (
            .clk      (clk),
            .arst_n   (arst_n),

            .wr_valid (in_valid[i]),
            .wr_ready (in_ready[i]),
            .wr_data  (in_data[i]),
            .wr_last  (in_last[i]),

            .rd_valid (lane_valid[i]),
            .rd_ready (lane_ready[i]),
            .rd_data  (lane_data[i]),
            .rd_last  (lane_last[i])
        );
    end

    lane_combiner i_lane_combiner (
        .clk        (clk),
        .arst_n     (arst_n),
        .trunc      (trunc),
        .lane_mask  (lane_mask),

        .lane_valid (lane_valid),
        .lane_data  (lane_data),
        .lane_last  (lane_last),
        .lane_ready (lane_ready),

        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_last   (out_last),
        .out_ready  (out_ready)
    );

endmodule

// File: logic/lane_combiner.sv
//##########################################################################
// joins the four lane FIFOs and sums their samples per channel
// four register stages, all of which hold while the output is stalled
//##########################################################################
`timescale 1ns/1ps

module lane_combiner import combine_pkg::*; (
    input  logic                         clk,
    input  logic                         arst_n,
    input  trunc_t                       trunc,
    input  logic [num_lanes-1:0]         lane_mask,

    input  logic [num_lanes-1:0]         lane_valid,
    input  sample_word_u [num_lanes-1:0] lane_data,
    input  logic [num_lanes-1:0]         lane_last,
    output logic [num_lanes-1:0]         lane_ready,

    output logic                         out_valid,
    output sample_word_u                 out_data,
    output logic                         out_last,
    input  logic                         out_ready
);

    logic [num_lanes-1:0] present;
    logic                 advance;
    logic                 join_fire;

    // stage 0 with masked lanes already zeroed
    sample_word_u [num_lanes-1:0] s0_word;
    logic                         s0_valid;
    logic                         s0_last;

    // stage 1 pair sums per channel
    logic signed [sample_w:0] s1_a01;
    logic signed [sample_w:0] s1_a23;
    logic signed [sample_w:0] s1_b01;
    logic signed [sample_w:0] s1_b23;
    logic                     s1_valid;
    logic                     s1_last;

    // stage 2 full totals
    logic signed [sum_w-1:0] s2_a;
    logic signed [sum_w-1:0] s2_b;
    logic                    s2_valid;
    logic                    s2_last;

    // picks the 16-bit window of a total without saturation
    function automatic logic [sample_w-1:0] scale(
        input trunc_t                  code,
        input logic signed [sum_w-1:0] sum
    );
        case (code)
            trunc_div2: return sum[sample_w:1];
            trunc_div4: return sum[sample_w+1:2];
            default:    return sum[sample_w-1:0];
        endcase
    endfunction

    assign present = lane_valid | lane_mask;
    assign advance = !out_valid || out_ready;

    // an all-masked setup never joins
    assign join_fire = advance && (&present) && !(&lane_mask);

    assign lane_ready = {num_lanes{join_fire}} & ~lane_mask;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s0_valid  <= 1'b0;
            s1_valid  <= 1'b0;
            s2_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            s0_valid  <= join_fire;
            s1_valid  <= s0_valid;
            s2_valid  <= s1_valid;
            out_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (join_fire) begin
            for (int i = 0; i < num_lanes; i++) begin
                s0_word[i] <= lane_mask[i] ? '0 : lane_data[i];
            end
            // masked lanes count as frame ends
            s0_last <= &(lane_last | lane_mask);
        end

        if (advance) begin
            s1_a01  <= s0_word[0].s.a + s0_word[1].s.a;
            s1_a23  <= s0_word[2].s.a + s0_word[3].s.a;
            s1_b01  <= s0_word[0].s.b + s0_word[1].s.b;
            s1_b23  <= s0_word[2].s.b + s0_word[3].s.b;
            s1_last <= s0_last;

            s2_a    <= s1_a01 + s1_a23;
            s2_b    <= s1_b01 + s1_b23;
            s2_last <= s1_last;

            out_data.s.a <= scale(trunc, s2_a);
            out_data.s.b <= scale(trunc, s2_b);
            out_last     <= s2_last;
        end
    end

    // downstream sees a steady word until it accepts it
    a_out_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
    );

endmodule

// File: logic/lane_fifo.sv
//##########################################################################
// skew FIFO for one input lane, holds a word and its frame end
// write side faces the lane input, read side feeds the combiner join
//##########################################################################
`timescale 1ns/1ps

module lane_fifo import combine_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,

    input  logic         wr_valid,
    output logic         wr_ready,
    input  sample_word_u wr_data,
    input  logic         wr_last,

    output logic         rd_valid,
    input  logic         rd_ready,
    output sample_word_u rd_data,
    output logic         rd_last
);

    sample_word_u mem      [lane_fifo_depth];
    logic         last_mem [lane_fifo_depth];

    logic [$clog2(lane_fifo_depth)-1:0]   wr_ptr;
    logic [$clog2(lane_fifo_depth)-1:0]   rd_ptr;
    logic [$clog2(lane_fifo_depth+1)-1:0] count;

    logic wr_fire;
    logic rd_fire;

    function automatic logic [$clog2(lane_fifo_depth)-1:0] ptr_inc(
        input logic [$clog2(lane_fifo_depth)-1:0] ptr
    );
        if (ptr == lane_fifo_depth - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign wr_ready = (count != lane_fifo_depth);
    assign rd_valid = (count != '0);

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    // head of queue is read straight out of the array
    assign rd_data = mem[rd_ptr];
    assign rd_last = last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr]      <= wr_data;
            last_mem[wr_ptr] <= wr_last;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // simultaneous push and pop leaves the count alone
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        count <= lane_fifo_depth
    );

    // held head word must not move until the combiner takes it
    a_rd_stable: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data) && $stable(rd_last)
    );

endmodule
